/* testbench/hub_vectors.txt */
# test en mask | op addr wdata for ports 0..3 | expected rdata ports 0..3 | ack order
# op 0 read 1 write 2 fetch-add; mask, addr and data in hex; unused order slots are 9
1 1 1  1 10 deadbeef  0 0 0  0 0 0  0 0 0  0 0 0 0  0 9 9 9
1 1 1  0 10 0  0 0 0  0 0 0  0 0 0  deadbeef 0 0 0  0 9 9 9
1 1 4  0 0 0  0 0 0  1 20 12345678  0 0 0  0 0 0 0  2 9 9 9
1 1 4  0 0 0  0 0 0  0 20 0  0 0 0  0 0 12345678 0  2 9 9 9
# fixed priority, all ports at once
2 1 f  1 30 a0  1 31 a1  1 32 a2  1 33 a3  0 0 0 0  0 1 2 3
2 1 f  0 33 0  0 32 0  0 31 0  0 30 0  a3 a2 a1 a0  0 1 2 3
2 1 e  0 0 0  0 30 0  0 31 0  0 32 0  0 a0 a1 a2  1 2 3 9
2 1 a  0 0 0  0 33 0  0 0 0  0 10 0  0 a3 0 deadbeef  1 3 9 9
# fetch-add, lower port sees the original value
3 1 8  0 0 0  0 0 0  0 0 0  1 40 100  0 0 0 0  3 9 9 9
3 1 6  0 0 0  2 40 5  2 40 7  0 0 0  0 100 105 0  1 2 9 9
3 1 1  0 40 0  0 0 0  0 0 0  0 0 0  10c 0 0 0  0 9 9 9
3 1 2  0 0 0  1 41 ffffffff  0 0 0  0 0 0  0 0 0 0  1 9 9 9
3 1 5  2 41 2  0 0 0  2 41 10  0 0 0  ffffffff 0 1 0  0 2 9 9
3 1 8  0 0 0  0 0 0  0 0 0  0 41 0  0 0 0 11  3 9 9 9
# writes answer zero, mixed group stays isolated
4 1 f  0 10 0  1 50 aaaa5555  0 20 0  1 51 5555aaaa  deadbeef 0 12345678 0  0 1 2 3
4 1 9  0 51 0  0 0 0  0 0 0  0 50 0  5555aaaa 0 0 aaaa5555  0 3 9 9
# enable low for 20 cycles, then raised
5 0 f  0 30 0  0 31 0  0 32 0  0 33 0  a0 a1 a2 a3  0 1 2 3
5 0 6  0 0 0  2 30 1  0 40 0  0 0 0  0 a0 10c 0  1 2 9 9
5 1 1  0 30 0  0 0 0  0 0 0  0 0 0  a1 0 0 0  0 9 9 9

/* shared_memory_hub.f */
source/mem_pkg.sv
source/cmd_pkg.sv
source/priority_arbiter.sv
source/shared_memory.sv
source/response_router.sv
source/shared_memory_hub.sv
testbench/clock_gen.sv
testbench/shared_memory_hub_chk.sv
testbench/tb_shared_memory_hub.sv

/* run.sh */
#!/usr/bin/env bash
# builds the hub testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_shared_memory_hub -f shared_memory_hub.f -o sim_hub
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/sim_hub)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" <<< "$output"; then
  exit 0
fi
exit 1

/* testbench/tb_shared_memory_hub.sv */
// --------------------
// testbench for the shared memory hub with 4 ports
// groups come from testbench/hub_vectors.txt, run from the project root
// every word is written before it is read
// inputs change on the falling edge, outputs sampled there too
// --------------------

module tb_shared_memory_hub;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_ports  = 4;
  localparam int max_groups = 64;
  localparam int dw = mem_pkg::data_width;
  localparam int aw = mem_pkg::addr_width;
  localparam int ow = cmd_pkg::op_width;

  logic clock, rstn, enable;
  logic [num_ports-1:0]    port_cyc, port_stb, port_we, port_ack;
  logic [num_ports*ow-1:0] port_op;
  logic [num_ports*aw-1:0] port_addr;
  logic [num_ports*dw-1:0] port_wdata, port_rdata;

  // one entry per vector line
  int             v_test [max_groups];
  int             v_en [max_groups];
  logic [3:0]     v_mask [max_groups];
  logic [ow-1:0]  v_op [max_groups][num_ports];
  logic [aw-1:0]  v_addr [max_groups][num_ports];
  logic [dw-1:0]  v_wdata [max_groups][num_ports];
  logic [dw-1:0]  v_exp [max_groups][num_ports];
  int             v_ord [max_groups][num_ports];
  int n_groups = 0;
  int errors   = 0;
  bit loaded   = 1'b0;

  clock_gen i_clock_gen (.clock(clock), .rstn(rstn));

  shared_memory_hub #(.num_ports(num_ports)) i_shared_memory_hub (
    .clock(clock), .rstn(rstn), .enable(enable),
    .port_cyc(port_cyc), .port_stb(port_stb), .port_we(port_we),
    .port_op(port_op), .port_addr(port_addr), .port_wdata(port_wdata),
    .port_ack(port_ack), .port_rdata(port_rdata)
  );

  bind priority_arbiter shared_memory_hub_chk #(.num_ports(num_ports)) i_shared_memory_hub_chk (
    .clock(clock), .rstn(rstn), .grant(grant), .m_cyc(m_cyc), .m_stb(m_stb),
    .m_ack(m_ack), .state(state)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // --------------------
  // vector file
  // --------------------
  task automatic load_vectors(output bit ok);
    int    fd;
    int    n;
    string line;
    ok = 1'b1;
    fd = $fopen("testbench/hub_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/hub_vectors.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd) && n_groups < max_groups) begin
        line = "";
        n = $fgets(line, fd);
        // comment lines start with #
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d %d %d",
            v_test[n_groups], v_en[n_groups], v_mask[n_groups],
            v_op[n_groups][0], v_addr[n_groups][0], v_wdata[n_groups][0],
            v_op[n_groups][1], v_addr[n_groups][1], v_wdata[n_groups][1],
            v_op[n_groups][2], v_addr[n_groups][2], v_wdata[n_groups][2],
            v_op[n_groups][3], v_addr[n_groups][3], v_wdata[n_groups][3],
            v_exp[n_groups][0], v_exp[n_groups][1], v_exp[n_groups][2], v_exp[n_groups][3],
            v_ord[n_groups][0], v_ord[n_groups][1], v_ord[n_groups][2], v_ord[n_groups][3]);
          if (n == 23) begin
            n_groups++;
          end else if (n > 0) begin
            $display("malformed vector line: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (n_groups == 0) begin
        $display("vector file holds no groups");
        ok = 1'b0;
      end
    end
  endtask

  // --------------------
  // one group, all requests start together
  // --------------------
  task automatic run_group(input int g);
    logic [num_ports-1:0] pending;
    logic [dw-1:0]        got_data [num_ports];
    int                   got_order [num_ports];
    int                   done;
    int                   cycles;
    bit                   single;
    pending = v_mask[g];
    done    = 0;
    cycles  = 0;
    // exact latency only holds uncontended and enabled
    single  = ($countones(v_mask[g]) == 1) && (v_en[g] == 1);
    enable  = (v_en[g] != 0);
    for (int p = 0; p < num_ports; p++) begin
      port_op[p*ow +: ow]    = v_op[g][p];
      port_addr[p*aw +: aw]  = v_addr[g][p];
      port_wdata[p*dw +: dw] = v_wdata[g][p];
      port_we[p]             = (v_op[g][p] != cmd_pkg::op_read);
      got_data[p]            = '0;
      got_order[p]           = 9;
    end
    port_cyc = v_mask[g];
    port_stb = v_mask[g];
    while (pending != 0) begin
      @(negedge clock);
      cycles++;
      if (!enable) begin
        // held off, nothing may finish
        check_value("port_ack with enable low", 0, 32'(port_ack));
        if (cycles == 20) begin
          enable = 1'b1;
        end
      end else if (port_ack != 0) begin
        check_value("acks in one cycle", 1, $countones(port_ack));
        check_value("port_ack to an idle port", 0, 32'(port_ack & ~pending));
        for (int p = 0; p < num_ports; p++) begin
          if (port_ack[p] && pending[p]) begin
            got_data[p]     = port_rdata[p*dw +: dw];
            got_order[done] = p;
            done++;
            pending[p]  = 1'b0;
            port_cyc[p] = 1'b0;
            port_stb[p] = 1'b0;
            if (single) begin
              check_value("uncontended ack latency", 4, cycles);
            end
          end else begin
            // isolation, no data leaks to others
            check_value($sformatf("port_rdata[%0d] of idle port", p), 0, port_rdata[p*dw +: dw]);
          end
        end
      end
    end
    for (int p = 0; p < num_ports; p++) begin
      if (v_mask[g][p]) begin
        check_value($sformatf("port_rdata[%0d]", p), v_exp[g][p], got_data[p]);
      end
    end
    for (int i = 0; i < done; i++) begin
      check_value($sformatf("ack order slot %0d", i), v_ord[g][i], got_order[i]);
    end
    // release cycle plus margin, arbiter idle again
    enable = 1'b1;
    repeat (3) @(negedge clock);
  endtask

  initial begin
    bit ok;
    int test_start;
    int tests_passed;
    int tests_failed;
    test_start   = 0;
    tests_passed = 0;
    tests_failed = 0;
    enable       = 1'b0;
    port_cyc     = '0;
    port_stb     = '0;
    port_we      = '0;
    port_op      = '0;
    port_addr    = '0;
    port_wdata   = '0;
    load_vectors(ok);
    if (!ok) begin
      $display("vector file could not be loaded, no test was run");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      wait (rstn === 1'b1);
      @(negedge clock);
      for (int g = 0; g < n_groups; g++) begin
        if (g == 0 || v_test[g] != v_test[g-1]) begin
          test_start = errors;
        end
        run_group(g);
        // last group of this test
        if (g == n_groups - 1 || v_test[g+1] != v_test[g]) begin
          if (errors == test_start) begin
            tests_passed++;
            $display("test %0d passed", v_test[g]);
          end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", v_test[g], errors - test_start);
          end
        end
      end
      $display("tests passed %0d, tests failed %0d, failed checks %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

  // watchdog, 40 cycles per group plus reset
  initial begin
    wait (loaded);
    repeat (n_groups * 40 + 10) @(posedge clock);
    $display("simulation timed out, a transfer never completed");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* testbench/shared_memory_hub_chk.sv */
// --------------------
// protocol checks on the arbiter, bound into priority_arbiter
// sampled on the rising clock, idle during reset
// --------------------

module shared_memory_hub_chk #(
  parameter int num_ports = 4
) (
  input logic                 clock,
  input logic                 rstn,
  input logic [num_ports-1:0] grant,
  input logic                 m_cyc,
  input logic                 m_stb,
  input logic                 m_ack,
  input cmd_pkg::arb_state_t  state
);
  timeunit 1ns;
  timeprecision 100ps;

  // at most one winner
  grant_onehot: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(grant)) else $error("grant has more than one bit set");

  // strobe stays inside its cycle until the memory acks
  stb_in_cyc: assert property (@(posedge clock) disable iff (!rstn)
    (m_stb && !m_ack) |=> (m_cyc && m_stb)) else $error("m_stb or m_cyc dropped before m_ack");

  // winner fixed for the whole transfer
  grant_stable: assert property (@(posedge clock) disable iff (!rstn)
    (state == cmd_pkg::st_busy) |=> $stable(grant)) else $error("grant changed while busy");

  // release only follows an ack and keeps the bus idle
  no_cyc_release: assert property (@(posedge clock) disable iff (!rstn)
    (state == cmd_pkg::st_release) |-> (!m_cyc && $past(m_ack)))
    else $error("release without a preceding m_ack, or m_cyc high in release");

endmodule

/* testbench/clock_gen.sv */
// --------------------
// free-running 8 ns clock
// rstn low for the first 10 rising edges
// rstn rises on a falling edge, away from the sampling edge
// --------------------

module clock_gen (
  output logic clock,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  // half period 4 ns
  initial clock = 1'b0;
  always #4 clock = ~clock;

  initial begin
    rstn = 1'b0;
    repeat (10) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
  end

endmodule

/* source/shared_memory_hub.sv */
// --------------------
// shared memory hub top level
// num_ports peers, each a Wishbone classic slave port
// per-port buses are flat vectors, port i in slice i
// num_ports legal from 1 to 8
// --------------------

module shared_memory_hub #(
  parameter int num_ports = 4
) (
  input  logic                                      clock,
  input  logic                                      rstn,
  input  logic                                      enable,
  input  logic [num_ports-1:0]                      port_cyc,
  input  logic [num_ports-1:0]                      port_stb,
  input  logic [num_ports-1:0]                      port_we,
  input  logic [num_ports*cmd_pkg::op_width-1:0]    port_op,
  input  logic [num_ports*mem_pkg::addr_width-1:0]  port_addr,
  input  logic [num_ports*mem_pkg::data_width-1:0]  port_wdata,
  output logic [num_ports-1:0]                      port_ack,
  output logic [num_ports*mem_pkg::data_width-1:0]  port_rdata
);

  // internal master bus
  logic                           m_cyc;
  logic                           m_stb;
  logic                           m_we;
  cmd_pkg::mem_op_t               m_op;
  logic [mem_pkg::addr_width-1:0] m_addr;
  logic [mem_pkg::data_width-1:0] m_wdata;
  logic                           m_ack;
  logic [mem_pkg::data_width-1:0] m_rdata;
  logic [num_ports-1:0]           grant;

  // N in, 1 out
  priority_arbiter #(
    .num_ports (num_ports)
  ) i_priority_arbiter (
    .clock      (clock),
    .rstn       (rstn),
    .enable     (enable),
    .port_cyc   (port_cyc),
    .port_stb   (port_stb),
    .port_we    (port_we),
    .port_op    (port_op),
    .port_addr  (port_addr),
    .port_wdata (port_wdata),
    .m_ack      (m_ack),
    .m_cyc      (m_cyc),
    .m_stb      (m_stb),
    .m_we       (m_we),
    .m_op       (m_op),
    .m_addr     (m_addr),
    .m_wdata    (m_wdata),
    .grant      (grant)
  );

  shared_memory i_shared_memory (
    .clock   (clock),
    .rstn    (rstn),
    .m_cyc   (m_cyc),
    .m_stb   (m_stb),
    .m_we    (m_we),
    .m_op    (m_op),
    .m_addr  (m_addr),
    .m_wdata (m_wdata),
    .m_ack   (m_ack),
    .m_rdata (m_rdata)
  );

  // 1 in, N out
  response_router #(
    .num_ports (num_ports)
  ) i_response_router (
    .clock      (clock),
    .rstn       (rstn),
    .grant      (grant),
    .m_ack      (m_ack),
    .m_rdata    (m_rdata),
    .port_ack   (port_ack),
    .port_rdata (port_rdata)
  );

endmodule

/* source/response_router.sv */
// --------------------
// steers the memory response to the granted port
// one register stage, so port_ack trails m_ack by a cycle
// rdata is zero on every port except the one being acked
// --------------------

module response_router #(
  parameter int num_ports = 4
) (
  input  logic                                      clock,
  input  logic                                      rstn,
  input  logic [num_ports-1:0]                      grant,
  input  logic                                      m_ack,
  input  logic [mem_pkg::data_width-1:0]            m_rdata,
  output logic [num_ports-1:0]                      port_ack,
  output logic [num_ports*mem_pkg::data_width-1:0]  port_rdata
);

  // ack qualified per port
  logic [num_ports-1:0] hit;

  assign hit = grant & {num_ports{m_ack}};

  // --------------------
  // output registers
  // --------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      port_ack   <= '0;
      port_rdata <= '0;
    end else begin
      port_ack <= hit;
      for (int i = 0; i < num_ports; i++) begin
        // only the winner sees data
        if (hit[i]) begin
          port_rdata[i*mem_pkg::data_width +: mem_pkg::data_width] <= m_rdata;
        end else begin
          port_rdata[i*mem_pkg::data_width +: mem_pkg::data_width] <= '0;
        end
      end
    end
  end

endmodule

/* source/shared_memory.sv */
// --------------------
// word memory behind a Wishbone classic slave
// ack is a one-cycle pulse, one cycle after the strobe is sampled
// contents are undefined until written
// strobe is ignored while ack is high, so nothing runs twice
// --------------------

module shared_memory (
  input  logic                           clock,
  input  logic                           rstn,
  input  logic                           m_cyc,
  input  logic                           m_stb,
  input  logic                           m_we,
  input  cmd_pkg::mem_op_t               m_op,
  input  logic [mem_pkg::addr_width-1:0] m_addr,
  input  logic [mem_pkg::data_width-1:0] m_wdata,
  output logic                           m_ack,
  output logic [mem_pkg::data_width-1:0] m_rdata
);

  logic [mem_pkg::data_width-1:0] mem_array [mem_pkg::mem_depth];

  // request accepted, executes next edge
  logic pending;

  logic [mem_pkg::data_width-1:0] old_word;
  logic [mem_pkg::data_width-1:0] wr_data;
  logic [mem_pkg::data_width-1:0] result;
  logic                           wr_en;

  assign old_word = mem_array[m_addr];

  // --------------------
  // opcode decode
  // --------------------
  always_comb begin
    wr_en   = 1'b0;
    wr_data = m_wdata;
    result  = '0;
    case (m_op)
      cmd_pkg::op_read: begin
        result = old_word;
      end
      // write answers with zero
      cmd_pkg::op_write: begin
        wr_en = m_we;
      end
      // old word back, sum stored
      cmd_pkg::op_fetch_add: begin
        wr_en   = m_we;
        wr_data = old_word + m_wdata;
        result  = old_word;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // --------------------
  // handshake
  // --------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pending <= 1'b0;
      m_ack   <= 1'b0;
      m_rdata <= '0;
    end else begin
      m_ack <= 1'b0;
      if (pending) begin
        pending <= 1'b0;
        m_ack   <= 1'b1;
        m_rdata <= result;
      end else if (m_cyc && m_stb && !m_ack) begin
        pending <= 1'b1;
      end
    end
  end

  // array update in the execute cycle
  always_ff @(posedge clock) begin
    if (pending && wr_en) begin
      mem_array[m_addr] <= wr_data;
    end
  end

endmodule

/* source/priority_arbiter.sv */
// --------------------
// fixed-priority arbiter, port 0 highest
// grant is latched for a whole transfer, no fairness
// enable low blocks new grants only, a granted transfer still ends
// one release cycle follows every ack before the next decision
// --------------------

module priority_arbiter #(
  parameter int num_ports = 4
) (
  input  logic                                      clock,
  input  logic                                      rstn,
  input  logic                                      enable,
  input  logic [num_ports-1:0]                      port_cyc,
  input  logic [num_ports-1:0]                      port_stb,
  input  logic [num_ports-1:0]                      port_we,
  input  logic [num_ports*cmd_pkg::op_width-1:0]    port_op,
  input  logic [num_ports*mem_pkg::addr_width-1:0]  port_addr,
  input  logic [num_ports*mem_pkg::data_width-1:0]  port_wdata,
  input  logic                                      m_ack,
  output logic                                      m_cyc,
  output logic                                      m_stb,
  output logic                                      m_we,
  output cmd_pkg::mem_op_t                          m_op,
  output logic [mem_pkg::addr_width-1:0]            m_addr,
  output logic [mem_pkg::data_width-1:0]            m_wdata,
  output logic [num_ports-1:0]                      grant
);

  cmd_pkg::arb_state_t  state;
  logic [num_ports-1:0] req;
  logic [num_ports-1:0] pick;

  // a port requests with cyc and stb both high
  assign req = port_cyc & port_stb;

  // lowest set index wins, scan from the top so it overrides
  always_comb begin
    pick = '0;
    for (int i = num_ports - 1; i >= 0; i--) begin
      if (req[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  // --------------------
  // grant FSM
  // --------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= cmd_pkg::st_idle;
      grant <= '0;
    end else begin
      case (state)
        cmd_pkg::st_idle: begin
          if (enable && (|req)) begin
            grant <= pick;
            state <= cmd_pkg::st_busy;
          end
        end
        // hold until the memory answers
        cmd_pkg::st_busy: begin
          if (m_ack) begin
            state <= cmd_pkg::st_release;
          end
        end
        // winner drops stb here
        cmd_pkg::st_release: begin
          grant <= '0;
          state <= cmd_pkg::st_idle;
        end
        default: begin
          grant <= '0;
          state <= cmd_pkg::st_idle;
        end
      endcase
    end
  end

  // master strobes only while busy
  assign m_cyc = (state == cmd_pkg::st_busy);
  assign m_stb = m_cyc & (|(grant & port_stb));

  // --------------------
  // master bus mux
  // --------------------
  always_comb begin
    m_we    = 1'b0;
    m_op    = cmd_pkg::op_read;
    m_addr  = '0;
    m_wdata = '0;
    for (int i = 0; i < num_ports; i++) begin
      if (grant[i]) begin
        m_we    = port_we[i];
        m_op    = cmd_pkg::mem_op_t'(port_op[i*cmd_pkg::op_width +: cmd_pkg::op_width]);
        m_addr  = port_addr[i*mem_pkg::addr_width +: mem_pkg::addr_width];
        m_wdata = port_wdata[i*mem_pkg::data_width +: mem_pkg::data_width];
      end
    end
  end

endmodule

/* source/cmd_pkg.sv */
// --------------------
// opcode and arbiter state encodings
// opcode codes 0, 1, 2 are also used in the vector file
// code 3 is unused and executes as a no-op
// --------------------

package cmd_pkg;

  // width of one port's opcode field on the flat bus
  localparam int op_width = 2;

  // memory operations
  typedef enum logic [op_width-1:0] {
    op_read      = 2'd0,
    op_write     = 2'd1,
    op_fetch_add = 2'd2
  } mem_op_t;

  // arbiter FSM
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_busy    = 2'd1,
    st_release = 2'd2
  } arb_state_t;

endpackage

/* source/mem_pkg.sv */
// --------------------
// memory geometry shared by the hub RTL and the testbench
// word addressed only, no byte lanes
// depth always follows addr_width, so the array is a power of two
// --------------------

package mem_pkg;

  // --------------------
  // word and address widths
  // --------------------

  // one memory word, also the width of every data bus
  localparam int data_width = 32;

  // word address, 256 words
  localparam int addr_width = 8;

  // number of words in the array
  localparam int mem_depth = 1 << addr_width;

endpackage
